/* common/soc_pkg.sv */
package soc_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int AHB_ADDR_W = 32;
    localparam int AHB_DATA_W = 64;
    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;

    typedef logic [AHB_ADDR_W-1:0] ahb_addr_t;
    typedef logic [AHB_DATA_W-1:0] ahb_data_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // AHB-lite transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Owner of an AHB data phase
    typedef enum logic [1:0] {
        SLV_NONE = 2'b00,
        SLV_LMEM = 2'b01,
        SLV_MBOX = 2'b10
    } slave_sel_t;

    // --------------------
    // Address map
    // --------------------
    // Each 64 KiB region ignores the low 16 bits in the match
    localparam ahb_addr_t LMEM_BASE   = 32'h5000_0000;
    localparam ahb_addr_t MBOX_BASE   = 32'h3000_0000;
    localparam logic [31:0] REGION_MASK = 32'h0000_FFFF;

    // --------------------
    // Mailbox registers
    // --------------------
    // Same offsets on the APB and the AHB window
    localparam logic [31:0] MBOX_DATA_OFS = 32'h0000_0000;
    localparam logic [31:0] MBOX_CTRL_OFS = 32'h0000_0004;
    localparam logic [31:0] MBOX_STAT_OFS = 32'h0000_0008;

    // Bit positions inside CTRL and STAT
    localparam int CTRL_EXEC_BIT  = 0;
    localparam int STAT_DONE_BIT  = 0;
    localparam int STAT_COUNT_LSB = 4;

endpackage

/* source/ahb_decoder.sv */
`timescale 1ns/100ps

module ahb_decoder (
    input  logic               core_clk,
    input  logic               arst_n_i,
    input  soc_pkg::ahb_addr_t haddr_i,
    input  soc_pkg::htrans_t   htrans_i,
    input  soc_pkg::ahb_data_t lmem_rdata_i,
    input  soc_pkg::ahb_data_t mbox_rdata_i,
    input  logic               lmem_ready_i,
    input  logic               mbox_ready_i,
    output logic               lmem_sel_o,
    output logic               mbox_sel_o,
    output soc_pkg::ahb_data_t hrdata_o,
    output logic               hready_o,
    output logic               hresp_o
);

    import soc_pkg::*;

    // Default slave gives a two-cycle error response
    typedef enum logic [1:0] {
        ERR_IDLE = 2'b00,
        ERR_WAIT = 2'b01,
        ERR_LAST = 2'b10
    } err_state_t;

    logic       xfer_active;
    logic       xfer_accept;
    slave_sel_t addr_sel;
    slave_sel_t data_sel_q;
    err_state_t err_q;
    err_state_t err_d;

    // --------------------
    // Address phase
    // --------------------
    assign xfer_active = (htrans_i == NONSEQ) || (htrans_i == SEQ);
    assign xfer_accept = xfer_active && hready_o;

    always_comb
    begin
        addr_sel = SLV_NONE;
        if (xfer_active)
        begin
            if ((haddr_i & ~REGION_MASK) == LMEM_BASE)
                addr_sel = SLV_LMEM;
            else if ((haddr_i & ~REGION_MASK) == MBOX_BASE)
                addr_sel = SLV_MBOX;
        end
    end

    assign lmem_sel_o = (addr_sel == SLV_LMEM);
    assign mbox_sel_o = (addr_sel == SLV_MBOX);

    // Unmapped active transfer starts the error sequence
    always_comb
    begin
        err_d = ERR_IDLE;
        if (err_q == ERR_WAIT)
            err_d = ERR_LAST;
        else if (xfer_accept && (addr_sel == SLV_NONE))
            err_d = ERR_WAIT;
    end

    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            data_sel_q <= SLV_NONE;
            err_q      <= ERR_IDLE;
        end
        else
        begin
            err_q <= err_d;
            // Owner only moves on when the bus advances
            if (hready_o)
                data_sel_q <= addr_sel;
        end
    end

    // --------------------
    // Data phase
    // --------------------
    always_comb
    begin
        hrdata_o = '0;
        hready_o = 1'b1;
        case (data_sel_q)
            SLV_LMEM:
            begin
                hrdata_o = lmem_rdata_i;
                hready_o = lmem_ready_i;
            end
            SLV_MBOX:
            begin
                hrdata_o = mbox_rdata_i;
                hready_o = mbox_ready_i;
            end
            default:
            begin
                hrdata_o = '0;
                hready_o = 1'b1;
            end
        endcase
        if (err_q == ERR_WAIT)
            hready_o = 1'b0;
    end

    assign hresp_o = (err_q != ERR_IDLE);

endmodule

/* source/ahb_lmem.sv */
`timescale 1ns/100ps

module ahb_lmem #(
    parameter int LMEM_DEPTH = 256
) (
    input  logic               core_clk,
    input  logic               arst_n_i,
    input  logic               sel_i,
    input  logic               hready_i,
    input  soc_pkg::ahb_addr_t haddr_i,
    input  logic               hwrite_i,
    input  soc_pkg::ahb_data_t hwdata_i,
    output soc_pkg::ahb_data_t rdata_o,
    output logic               readyout_o
);

    import soc_pkg::*;

    localparam int ADDR_W = (LMEM_DEPTH > 1) ? $clog2(LMEM_DEPTH) : 1;
    // Byte offset bits of one 64-bit word
    localparam int BYTE_W = $clog2(AHB_DATA_W / 8);

    ahb_data_t         mem [LMEM_DEPTH];
    logic              xfer_accept;
    logic              dp_valid_q;
    logic              dp_write_q;
    logic [ADDR_W-1:0] dp_addr_q;

    // --------------------
    // Address phase capture
    // --------------------
    assign xfer_accept = sel_i && hready_i;

    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            dp_valid_q <= 1'b0;
            dp_write_q <= 1'b0;
            dp_addr_q  <= '0;
        end
        else if (hready_i)
        begin
            dp_valid_q <= xfer_accept;
            if (xfer_accept)
            begin
                dp_write_q <= hwrite_i;
                dp_addr_q  <= haddr_i[BYTE_W +: ADDR_W];
            end
        end
    end

    // --------------------
    // Storage
    // --------------------
    // Write lands at the end of the data phase
    always_ff @(posedge core_clk)
    begin
        if (dp_valid_q && dp_write_q && hready_i)
            mem[dp_addr_q] <= hwdata_i;
    end

    // Read data valid during the data phase
    assign rdata_o = mem[dp_addr_q];

    // Always zero wait states
    assign readyout_o = 1'b1;

endmodule

/* mbox/mbox_ctrl.sv */
`timescale 1ns/100ps

module mbox_ctrl #(
    parameter int MBOX_DEPTH = 8
) (
    input  logic               core_clk,
    input  logic               arst_n_i,
    input  soc_pkg::apb_addr_t paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  soc_pkg::apb_data_t pwdata_i,
    input  logic               ahb_sel_i,
    input  logic               hready_i,
    input  soc_pkg::ahb_addr_t haddr_i,
    input  logic               hwrite_i,
    input  soc_pkg::ahb_data_t hwdata_i,
    output logic               pready_o,
    output logic               pslverr_o,
    output soc_pkg::apb_data_t prdata_o,
    output soc_pkg::ahb_data_t ahb_rdata_o,
    output logic               ahb_readyout_o,
    output logic               data_avail_o,
    output logic               flow_done_o
);

    import soc_pkg::*;

    localparam int PTR_W = (MBOX_DEPTH > 1) ? $clog2(MBOX_DEPTH) : 1;
    localparam int CNT_W = $clog2(MBOX_DEPTH + 1);

    apb_data_t        fifo_mem [MBOX_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             fifo_full;
    logic             fifo_empty;
    logic             fifo_push;
    logic             fifo_pop;
    logic             fifo_flush;
    logic             exec_q;
    logic             done_q;
    logic [31:0]      apb_ofs;
    logic             apb_access;
    logic             apb_mapped;
    logic             apb_ctrl_wr;
    logic             ahb_dp_valid_q;
    logic             ahb_dp_write_q;
    logic [31:0]      ahb_ofs_q;
    logic             ahb_data_rd;
    logic             ahb_stat_wr;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(MBOX_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign fifo_full  = (count_q == CNT_W'(MBOX_DEPTH));
    assign fifo_empty = (count_q == '0);

    // --------------------
    // APB window
    // --------------------
    assign apb_ofs     = paddr_i & REGION_MASK;
    assign apb_access  = psel_i && penable_i;
    assign apb_mapped  = (apb_ofs == MBOX_DATA_OFS) || (apb_ofs == MBOX_CTRL_OFS) ||
                         (apb_ofs == MBOX_STAT_OFS);
    assign apb_ctrl_wr = apb_access && pwrite_i && (apb_ofs == MBOX_CTRL_OFS);

    assign fifo_push  = apb_access && pwrite_i && (apb_ofs == MBOX_DATA_OFS) && !fifo_full;
    assign fifo_flush = apb_ctrl_wr && !pwdata_i[CTRL_EXEC_BIT];

    assign pready_o  = 1'b1;
    assign pslverr_o = apb_access && (!apb_mapped ||
                       (pwrite_i && (apb_ofs == MBOX_DATA_OFS) && fifo_full));

    always_comb
    begin
        prdata_o = '0;
        if (apb_ofs == MBOX_CTRL_OFS)
        begin
            prdata_o[CTRL_EXEC_BIT] = exec_q;
        end
        else if (apb_ofs == MBOX_STAT_OFS)
        begin
            prdata_o[STAT_DONE_BIT]             = done_q;
            prdata_o[STAT_COUNT_LSB +: CNT_W]   = count_q;
        end
    end

    // --------------------
    // AHB window
    // --------------------
    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ahb_dp_valid_q <= 1'b0;
            ahb_dp_write_q <= 1'b0;
            ahb_ofs_q      <= '0;
        end
        else if (hready_i)
        begin
            ahb_dp_valid_q <= ahb_sel_i;
            if (ahb_sel_i)
            begin
                ahb_dp_write_q <= hwrite_i;
                ahb_ofs_q      <= haddr_i & REGION_MASK;
            end
        end
    end

    // Act when the data phase completes
    assign ahb_data_rd = ahb_dp_valid_q && hready_i && !ahb_dp_write_q &&
                         (ahb_ofs_q == MBOX_DATA_OFS);
    assign ahb_stat_wr = ahb_dp_valid_q && hready_i && ahb_dp_write_q &&
                         (ahb_ofs_q == MBOX_STAT_OFS) && hwdata_i[STAT_DONE_BIT];
    assign fifo_pop    = ahb_data_rd && !fifo_empty;

    always_comb
    begin
        ahb_rdata_o = '0;
        if (ahb_ofs_q == MBOX_DATA_OFS)
        begin
            // Empty FIFO reads as zero
            if (!fifo_empty)
                ahb_rdata_o[APB_DATA_W-1:0] = fifo_mem[rd_ptr_q];
        end
        else if (ahb_ofs_q == MBOX_CTRL_OFS)
        begin
            ahb_rdata_o[CNT_W-1:0] = count_q;
        end
        else if (ahb_ofs_q == MBOX_STAT_OFS)
        begin
            ahb_rdata_o[STAT_DONE_BIT] = done_q;
        end
    end

    assign ahb_readyout_o = 1'b1;

    // --------------------
    // FIFO
    // --------------------
    always_ff @(posedge core_clk)
    begin
        if (fifo_push)
            fifo_mem[wr_ptr_q] <= pwdata_i;
    end

    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (fifo_flush)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (fifo_push)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (fifo_pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            if (fifo_push && !fifo_pop)
                count_q <= count_q + 1'b1;
            else if (fifo_pop && !fifo_push)
                count_q <= count_q - 1'b1;
        end
    end

    // SoC control write wins over the controller status write
    always_ff @(posedge core_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            exec_q <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            if (ahb_stat_wr)
            begin
                done_q <= 1'b1;
                exec_q <= 1'b0;
            end
            if (apb_ctrl_wr)
            begin
                if (pwdata_i[CTRL_EXEC_BIT])
                begin
                    exec_q <= 1'b1;
                end
                else
                begin
                    exec_q <= 1'b0;
                    done_q <= 1'b0;
                end
            end
        end
    end

    assign data_avail_o = exec_q;
    assign flow_done_o  = done_q;

endmodule

/* source/soc_top.sv */
`timescale 1ns/100ps

module soc_top #(
    parameter int LMEM_DEPTH = 256,
    parameter int MBOX_DEPTH = 8
) (
    input  logic               core_clk,
    input  logic               arst_n_i,

    // AHB-lite from the controller load/store port
    input  soc_pkg::ahb_addr_t haddr_i,
    input  soc_pkg::htrans_t   htrans_i,
    input  logic               hwrite_i,
    input  soc_pkg::ahb_data_t hwdata_i,
    output soc_pkg::ahb_data_t hrdata_o,
    output logic               hready_o,
    output logic               hresp_o,

    // APB from the SoC
    input  soc_pkg::apb_addr_t paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  soc_pkg::apb_data_t pwdata_i,
    output logic               pready_o,
    output logic               pslverr_o,
    output soc_pkg::apb_data_t prdata_o,

    output logic               mailbox_data_avail_o,
    output logic               mailbox_flow_done_o
);

    logic               lmem_sel;
    logic               mbox_sel;
    logic               lmem_ready;
    logic               mbox_ready;
    soc_pkg::ahb_data_t lmem_rdata;
    soc_pkg::ahb_data_t mbox_rdata;

    // --------------------
    // AHB decode
    // --------------------
    ahb_decoder u_decoder (
        .core_clk     (core_clk),
        .arst_n_i     (arst_n_i),
        .haddr_i      (haddr_i),
        .htrans_i     (htrans_i),
        .lmem_rdata_i (lmem_rdata),
        .mbox_rdata_i (mbox_rdata),
        .lmem_ready_i (lmem_ready),
        .mbox_ready_i (mbox_ready),
        .lmem_sel_o   (lmem_sel),
        .mbox_sel_o   (mbox_sel),
        .hrdata_o     (hrdata_o),
        .hready_o     (hready_o),
        .hresp_o      (hresp_o)
    );

    // --------------------
    // Slaves
    // --------------------
    ahb_lmem #(
        .LMEM_DEPTH (LMEM_DEPTH)
    ) u_lmem (
        .core_clk   (core_clk),
        .arst_n_i   (arst_n_i),
        .sel_i      (lmem_sel),
        .hready_i   (hready_o),
        .haddr_i    (haddr_i),
        .hwrite_i   (hwrite_i),
        .hwdata_i   (hwdata_i),
        .rdata_o    (lmem_rdata),
        .readyout_o (lmem_ready)
    );

    mbox_ctrl #(
        .MBOX_DEPTH (MBOX_DEPTH)
    ) u_mbox (
        .core_clk       (core_clk),
        .arst_n_i       (arst_n_i),
        .paddr_i        (paddr_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .pwdata_i       (pwdata_i),
        .ahb_sel_i      (mbox_sel),
        .hready_i       (hready_o),
        .haddr_i        (haddr_i),
        .hwrite_i       (hwrite_i),
        .hwdata_i       (hwdata_i),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .prdata_o       (prdata_o),
        .ahb_rdata_o    (mbox_rdata),
        .ahb_readyout_o (mbox_ready),
        .data_avail_o   (mailbox_data_avail_o),
        .flow_done_o    (mailbox_flow_done_o)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held low for RST_CYCLES rising edges
    initial
    begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* dv/tb_assertions.sv */
`timescale 1ns/100ps

module tb_assertions (
    input logic             core_clk,
    input logic             arst_n_i,
    input soc_pkg::htrans_t htrans_i,
    input logic             lmem_sel_i,
    input logic             mbox_sel_i,
    input logic             hready_i,
    input logic             hresp_i,
    input logic             penable_i,
    input logic             pready_i,
    input logic             data_avail_i,
    input logic             flow_done_i
);

    import soc_pkg::*;

    // --------------------
    // AHB side
    // --------------------
    // Last error cycle always follows the wait cycle
    err_two_cycle: assert property (@(posedge core_clk) disable iff (!arst_n_i)
        (hresp_i && hready_i) |-> $past(hresp_i && !hready_i))
        else $error("error response completed without its wait cycle");

    no_sel_on_idle: assert property (@(posedge core_clk) disable iff (!arst_n_i)
        (htrans_i == IDLE) |-> !(lmem_sel_i || mbox_sel_i))
        else $error("slave selected during an IDLE transfer");

    // --------------------
    // APB and flags
    // --------------------
    apb_ready_in_access: assert property (@(posedge core_clk) disable iff (!arst_n_i)
        penable_i |-> pready_i)
        else $error("pready_o low in an APB access cycle");

    flags_low_after_reset: assert property (@(posedge core_clk)
        $rose(arst_n_i) |=> (!data_avail_i && !flow_done_i))
        else $error("mailbox flags not low after reset");

endmodule

bind soc_top tb_assertions u_assertions (
    .core_clk     (core_clk),
    .arst_n_i     (arst_n_i),
    .htrans_i     (htrans_i),
    .lmem_sel_i   (lmem_sel),
    .mbox_sel_i   (mbox_sel),
    .hready_i     (hready_o),
    .hresp_i      (hresp_o),
    .penable_i    (penable_i),
    .pready_i     (pready_o),
    .data_avail_i (mailbox_data_avail_o),
    .flow_done_i  (mailbox_flow_done_o)
);

/* dv/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

    import soc_pkg::*;

    localparam int LMEM_DEPTH  = 256;
    localparam int MBOX_DEPTH  = 8;
    localparam int TIMEOUT_CYC = 50;

    typedef enum logic [2:0] {
        OP_AHB_WR,
        OP_AHB_RD,
        OP_APB_WR,
        OP_APB_RD,
        OP_FLAGS
    } op_kind_t;

    // chain puts the address phase into the previous data phase
    // For OP_FLAGS exp bit 0 is data_avail and bit 1 is flow_done
    typedef struct {
        op_kind_t    kind;
        int          test_id;
        logic        chain;
        logic [31:0] addr;
        ahb_data_t   data;
        ahb_data_t   exp;
        logic        exp_err;
    } step_t;

    logic        core_clk;
    logic        arst_n;
    ahb_addr_t   haddr;
    htrans_t     htrans;
    logic        hwrite;
    ahb_data_t   hwdata;
    ahb_data_t   hrdata;
    logic        hready;
    logic        hresp;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_data_t   pwdata;
    logic        pready;
    logic        pslverr;
    apb_data_t   prdata;
    logic        data_avail;
    logic        flow_done;

    step_t       steps [$];
    string       test_names [1:6];
    logic [31:0] lfsr_q;
    int          check_cnt;
    int          err_cnt;
    int          test_cnt;
    int          fail_tests;
    logic        timed_out;

    tb_clk_gen #(
        .PERIOD_NS  (8),
        .RST_CYCLES (2)
    ) u_clk_gen (
        .clk_o    (core_clk),
        .arst_n_o (arst_n)
    );

    soc_top #(
        .LMEM_DEPTH (LMEM_DEPTH),
        .MBOX_DEPTH (MBOX_DEPTH)
    ) u_dut (
        .core_clk             (core_clk),
        .arst_n_i             (arst_n),
        .haddr_i              (haddr),
        .htrans_i             (htrans),
        .hwrite_i             (hwrite),
        .hwdata_i             (hwdata),
        .hrdata_o             (hrdata),
        .hready_o             (hready),
        .hresp_o              (hresp),
        .paddr_i              (paddr),
        .psel_i               (psel),
        .penable_i            (penable),
        .pwrite_i             (pwrite),
        .pwdata_i             (pwdata),
        .pready_o             (pready),
        .pslverr_o            (pslverr),
        .prdata_o             (prdata),
        .mailbox_data_avail_o (data_avail),
        .mailbox_flow_done_o  (flow_done)
    );

    // --------------------
    // Random data
    // --------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    function automatic ahb_data_t rand_data();
        ahb_data_t val;
        int        b;
        val = '0;
        for (b = 0; b < AHB_DATA_W; b++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[AHB_DATA_W-2:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_ahb_data(input string name, input ahb_data_t got, input ahb_data_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_apb_data(input string name, input apb_data_t got, input apb_data_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic add_step(input op_kind_t kind, input int test_id, input logic chain,
                            input logic [31:0] addr, input ahb_data_t data,
                            input ahb_data_t exp, input logic exp_err);
        step_t st;
        st.kind    = kind;
        st.test_id = test_id;
        st.chain   = chain;
        st.addr    = addr;
        st.data    = data;
        st.exp     = exp;
        st.exp_err = exp_err;
        steps.push_back(st);
    endtask

    task automatic build_table();
        ahb_data_t   d [6];
        logic [31:0] a [5];
        int          k;
        test_names[1] = "reset values";
        test_names[2] = "lmem write and read back";
        test_names[3] = "unmapped error response";
        test_names[4] = "mailbox push and pop";
        test_names[5] = "mailbox done handshake";
        test_names[6] = "mailbox overflow and bad offset";
        for (k = 0; k < 6; k++)
            d[k] = rand_data();
        a[0] = LMEM_BASE + 32'h000;
        a[1] = LMEM_BASE + 32'h008;
        a[2] = LMEM_BASE + 32'h010;
        a[3] = LMEM_BASE + 32'h7F8;
        a[4] = LMEM_BASE + 32'h400;

        add_step(OP_FLAGS, 1, 1'b0, '0, '0, 64'h0, 1'b0);

        // Pipelined writes, pipelined reads, then write followed at once by a read
        for (k = 0; k < 4; k++)
            add_step(OP_AHB_WR, 2, (k > 0), a[k], d[k], '0, 1'b0);
        for (k = 0; k < 4; k++)
            add_step(OP_AHB_RD, 2, (k > 0), a[k], '0, d[k], 1'b0);
        add_step(OP_AHB_WR, 2, 1'b0, a[4], d[4], '0, 1'b0);
        add_step(OP_AHB_RD, 2, 1'b1, a[4], '0, d[4], 1'b0);
        add_step(OP_AHB_RD, 2, 1'b0, a[0], '0, d[0], 1'b0);
        add_step(OP_AHB_WR, 2, 1'b1, a[0], d[5], '0, 1'b0);
        add_step(OP_AHB_RD, 2, 1'b1, a[0], '0, d[5], 1'b0);

        // The unmapped write aliases LMEM word 0 in its low address bits
        add_step(OP_AHB_RD, 3, 1'b0, 32'h7000_0010, '0, '0, 1'b1);
        add_step(OP_AHB_WR, 3, 1'b0, 32'h0000_1000, 64'hDEAD, '0, 1'b1);
        add_step(OP_AHB_RD, 3, 1'b0, a[0], '0, d[5], 1'b0);

        add_step(OP_APB_WR, 4, 1'b0, MBOX_DATA_OFS, 64'hA5A5_0001, '0, 1'b0);
        add_step(OP_APB_WR, 4, 1'b0, MBOX_DATA_OFS, 64'h5A5A_0002, '0, 1'b0);
        add_step(OP_APB_WR, 4, 1'b0, MBOX_DATA_OFS, 64'h0F0F_0003, '0, 1'b0);
        add_step(OP_APB_WR, 4, 1'b0, MBOX_CTRL_OFS, 64'h1, '0, 1'b0);
        add_step(OP_FLAGS, 4, 1'b0, '0, '0, 64'h1, 1'b0);
        add_step(OP_APB_RD, 4, 1'b0, MBOX_STAT_OFS, '0, 64'h30, 1'b0);
        add_step(OP_AHB_RD, 4, 1'b0, MBOX_BASE + MBOX_CTRL_OFS, '0, 64'h3, 1'b0);
        add_step(OP_AHB_RD, 4, 1'b0, MBOX_BASE + MBOX_DATA_OFS, '0, 64'hA5A5_0001, 1'b0);
        add_step(OP_AHB_RD, 4, 1'b1, MBOX_BASE + MBOX_DATA_OFS, '0, 64'h5A5A_0002, 1'b0);
        add_step(OP_AHB_RD, 4, 1'b1, MBOX_BASE + MBOX_DATA_OFS, '0, 64'h0F0F_0003, 1'b0);
        add_step(OP_AHB_RD, 4, 1'b1, MBOX_BASE + MBOX_DATA_OFS, '0, 64'h0, 1'b0);

        add_step(OP_AHB_WR, 5, 1'b0, MBOX_BASE + MBOX_STAT_OFS, 64'h1, '0, 1'b0);
        add_step(OP_FLAGS, 5, 1'b0, '0, '0, 64'h2, 1'b0);
        add_step(OP_APB_RD, 5, 1'b0, MBOX_STAT_OFS, '0, 64'h1, 1'b0);
        add_step(OP_APB_WR, 5, 1'b0, MBOX_CTRL_OFS, 64'h0, '0, 1'b0);
        add_step(OP_FLAGS, 5, 1'b0, '0, '0, 64'h0, 1'b0);

        // One push more than the FIFO holds
        for (k = 0; k <= MBOX_DEPTH; k++)
            add_step(OP_APB_WR, 6, 1'b0, MBOX_DATA_OFS, 64'hC000_0000 + k, '0,
                     (k == MBOX_DEPTH));
        add_step(OP_APB_RD, 6, 1'b0, MBOX_STAT_OFS, '0, MBOX_DEPTH << 4, 1'b0);
        add_step(OP_AHB_RD, 6, 1'b0, MBOX_BASE + MBOX_CTRL_OFS, '0, MBOX_DEPTH, 1'b0);
        add_step(OP_APB_RD, 6, 1'b0, 32'h0000_000C, '0, '0, 1'b1);
        add_step(OP_APB_WR, 6, 1'b0, 32'h0000_0010, 64'h1, '0, 1'b1);
        add_step(OP_APB_WR, 6, 1'b0, MBOX_CTRL_OFS, 64'h0, '0, 1'b0);
    endtask

    // --------------------
    // Bus drivers
    // --------------------
    task automatic drive_addr(input int idx);
        haddr  <= steps[idx].addr;
        htrans <= NONSEQ;
        hwrite <= (steps[idx].kind == OP_AHB_WR);
    endtask

    task automatic check_data_phase(input int idx, input logic first_ready,
                                    input logic first_resp);
        check_flag("hready_o first cycle", first_ready, !steps[idx].exp_err);
        check_flag("hresp_o first cycle", first_resp, steps[idx].exp_err);
        check_flag("hresp_o", hresp, steps[idx].exp_err);
        if (steps[idx].kind == OP_AHB_RD && !steps[idx].exp_err)
            check_ahb_data("hrdata_o", hrdata, steps[idx].exp);
    endtask

    // Runs num table rows as back-to-back pipelined transfers
    task automatic ahb_xfer(input int first, input int num);
        int   i;
        int   cyc;
        logic first_ready;
        logic first_resp;
        @(posedge core_clk);
        drive_addr(first);
        for (i = 0; i <= num; i++)
        begin
            @(negedge core_clk);
            first_ready = hready;
            first_resp  = hresp;
            cyc = 0;
            while (!hready && cyc < TIMEOUT_CYC)
            begin
                @(negedge core_clk);
                cyc++;
            end
            if (!hready)
            begin
                $display("timeout: hready_o stayed low for %0d cycles", TIMEOUT_CYC);
                timed_out = 1'b1;
                return;
            end
            if (i > 0)
                check_data_phase(first + i - 1, first_ready, first_resp);
            @(posedge core_clk);
            if (i + 1 < num)
                drive_addr(first + i + 1);
            else
                htrans <= IDLE;
            if (i < num)
                hwdata <= steps[first+i].data;
        end
    endtask

    task automatic apb_xfer(input int idx);
        int   cyc;
        logic first_ready;
        @(posedge core_clk);
        paddr   <= steps[idx].addr;
        pwrite  <= (steps[idx].kind == OP_APB_WR);
        pwdata  <= steps[idx].data[APB_DATA_W-1:0];
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge core_clk);
        penable <= 1'b1;
        @(negedge core_clk);
        first_ready = pready;
        cyc = 0;
        while (!pready && cyc < TIMEOUT_CYC)
        begin
            @(negedge core_clk);
            cyc++;
        end
        if (!pready)
        begin
            $display("timeout: pready_o stayed low for %0d cycles", TIMEOUT_CYC);
            timed_out = 1'b1;
            return;
        end
        check_flag("pready_o first access cycle", first_ready, 1'b1);
        check_flag("pslverr_o", pslverr, steps[idx].exp_err);
        if (steps[idx].kind == OP_APB_RD && !steps[idx].exp_err)
            check_apb_data("prdata_o", prdata, steps[idx].exp[APB_DATA_W-1:0]);
        @(posedge core_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_flags(input int idx);
        @(negedge core_clk);
        check_flag("mailbox_data_avail_o", data_avail, steps[idx].exp[0]);
        check_flag("mailbox_flow_done_o", flow_done, steps[idx].exp[1]);
        check_flag("hready_o", hready, 1'b1);
        check_flag("hresp_o", hresp, 1'b0);
    endtask

    task automatic report_test(input int id, input int errs_before);
        int errs;
        errs = err_cnt - errs_before;
        test_cnt++;
        if (errs == 0 && !timed_out)
        begin
            $display("test %0d (%s): pass", id, test_names[id]);
        end
        else
        begin
            fail_tests++;
            $display("test %0d (%s): fail, %0d errors", id, test_names[id], errs);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        int idx;
        int num;
        int cyc;
        int errs_before;
        haddr      = '0;
        htrans     = IDLE;
        hwrite     = 1'b0;
        hwdata     = '0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        lfsr_q     = 32'h9599;
        check_cnt  = 0;
        err_cnt    = 0;
        test_cnt   = 0;
        fail_tests = 0;
        timed_out  = 1'b0;
        build_table();

        cyc = 0;
        while (arst_n !== 1'b1 && cyc < TIMEOUT_CYC)
        begin
            @(posedge core_clk);
            cyc++;
        end
        if (arst_n !== 1'b1)
        begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end

        idx         = 0;
        errs_before = err_cnt;
        while (idx < steps.size() && !timed_out)
        begin
            case (steps[idx].kind)
                OP_AHB_WR, OP_AHB_RD:
                begin
                    num = 1;
                    while (idx + num < steps.size() && steps[idx+num].chain)
                        num++;
                    ahb_xfer(idx, num);
                    idx += num;
                end
                OP_APB_WR, OP_APB_RD:
                begin
                    apb_xfer(idx);
                    idx++;
                end
                default:
                begin
                    check_flags(idx);
                    idx++;
                end
            endcase
            if (timed_out || idx >= steps.size() ||
                steps[idx].test_id != steps[idx-1].test_id)
            begin
                report_test(steps[idx-1].test_id, errs_before);
                errs_before = err_cnt;
            end
        end

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, fail_tests, check_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb.f */
common/soc_pkg.sv
source/ahb_decoder.sv
source/ahb_lmem.sv
mbox/mbox_ctrl.sv
source/soc_top.sv
dv/tb_clk_gen.sv
dv/tb_assertions.sv
dv/tb_top.sv

/* Makefile */
SIM      := verilator
TOP      := tb_top
FILELIST := tb.f
SIMFLAGS := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := CHECKS FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
